// File: design/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data and address width of one word
`define MIPS_WORD_W 32

// architectural registers with r0 reading as zero
`define MIPS_REG_CNT 32

// one-word lines in the data cache
// must stay a power of two since the index is a plain bit slice
`define CACHE_LINES 16

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: design/mips_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    // primary opcode field in inst[31:26]
    typedef enum logic [5:0] {
        op_r_type = 6'h00,
        op_j      = 6'h02,
        op_beq    = 6'h04,
        op_addi   = 6'h08,
        op_lw     = 6'h23,
        op_sw     = 6'h2b
    } opcode_e;

    // funct field of r-type in inst[5:0]
    typedef enum logic [5:0] {
        fn_syscall = 6'h0c,
        fn_add     = 6'h20,
        fn_sub     = 6'h22,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_slt     = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0, // also the all-zero default
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    // decoded controls in 11 bits
    typedef struct packed {
        logic    reg_dst;    // 1 writes rd, 0 writes rt
        logic    jump;
        logic    branch;     // beq
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg; // write back load data
        logic    alu_src;    // 1 selects sign-extended immediate
        logic    reg_write;
        alu_op_e alu_op;
    } ctrl_t;

    // byte 0 is the most significant byte
    typedef logic [0:`MIPS_WORD_W/8-1][7:0] mem_word_t;

    typedef enum logic {
        cs_idle = 1'b0,
        cs_fill = 1'b1
    } cache_state_e;

endpackage

`default_nettype wire

// File: design/mips_control.sv
`timescale 1ns/100ps
`default_nettype none

module mips_control (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    output mips_pkg::ctrl_t   ctrl,
    output logic              syscall
);

    import mips_pkg::*;

    always_comb begin
        ctrl    = '0; // unknown encodings fall through as no-ops
        syscall = 1'b0;
        case (opcode)
            op_r_type: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    fn_add: ctrl.alu_op = alu_add;
                    fn_sub: ctrl.alu_op = alu_sub;
                    fn_and: ctrl.alu_op = alu_and;
                    fn_or:  ctrl.alu_op = alu_or;
                    fn_slt: ctrl.alu_op = alu_slt;
                    fn_syscall: begin
                        ctrl    = '0; // halt only with nothing written
                        syscall = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            op_addi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            op_lw: begin
                ctrl.alu_src    = 1'b1; // base + offset
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = alu_add;
            end
            op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub; // equal when the difference is zero
            end
            op_j:    ctrl.jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/mips_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_regfile (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic [4:0]              rs_num,
    input  logic [4:0]              rt_num,
    input  logic [4:0]              rd_num,
    input  logic [`MIPS_WORD_W-1:0] rd_data,
    input  logic                    rd_we,
    input  logic                    stall,  // load miss waiting for its fill
    input  logic                    halted,
    output logic [`MIPS_WORD_W-1:0] rs_data,
    output logic [`MIPS_WORD_W-1:0] rt_data
);

    logic [`MIPS_WORD_W-1:0] regs_q [`MIPS_REG_CNT];

    // r0 is never written and keeps its reset zero
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < `MIPS_REG_CNT; i++) regs_q[i] <= '0;
        end else if (rd_we && !stall && !halted && rd_num != 5'd0) begin
            regs_q[rd_num] <= rd_data;
        end
    end

    assign rs_data = regs_q[rs_num]; // async read ports
    assign rt_data = regs_q[rt_num];

endmodule

`default_nettype wire

// File: design/mips_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_alu (
    input  logic [`MIPS_WORD_W-1:0] a,
    input  logic [`MIPS_WORD_W-1:0] b,
    input  mips_pkg::alu_op_e       op,
    output logic [`MIPS_WORD_W-1:0] result,
    output logic                    zero
);

    import mips_pkg::*;

    logic less; // signed compare for slt

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: begin
                result    = '0;
                result[0] = less; // 1 when a < b
            end
            default: result = '0;
        endcase
    end

    // beq reads this through sub
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/mips_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_cache (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic [`MIPS_WORD_W-1:0] addr,         // byte address from the alu
    input  logic                    read_req,     // lw current
    input  logic                    write_req,    // sw current
    input  logic [`MIPS_WORD_W-1:0] write_data,   // rt data
    output logic [`MIPS_WORD_W-1:0] read_data,
    output logic                    done,         // low only while a miss waits for fill
    output logic [`MIPS_WORD_W-1:0] mem_addr,
    output mips_pkg::mem_word_t     mem_data_in,
    input  mips_pkg::mem_word_t     mem_data_out,
    output logic                    mem_write_en
);

    import mips_pkg::*;

    localparam int IDX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W = `MIPS_WORD_W - IDX_W - 2;

    logic [TAG_W-1:0]        tag_q   [`CACHE_LINES];
    logic [`MIPS_WORD_W-1:0] data_q  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    cache_state_e state_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             miss;
    logic             filling;

    assign idx     = addr[IDX_W+1:2]; // word address bits above the byte offset
    assign tag     = addr[`MIPS_WORD_W-1:IDX_W+2];
    assign hit     = valid_q[idx] && (tag_q[idx] == tag);
    assign filling = (state_q == cs_fill);
    assign miss    = read_req && !hit && !filling;

    // idle -> fill on a load miss and back after one cycle
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state_q <= cs_idle;
        end else begin
            case (state_q)
                cs_idle: if (miss) state_q <= cs_fill;
                cs_fill: state_q <= cs_idle;
                default: state_q <= cs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            valid_q <= '0;
        end else if (filling) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // line payload captured on fill or refreshed by a store hit
    always_ff @(posedge clk) begin
        if (filling) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_data_out;
        end else if (write_req && hit) begin
            data_q[idx] <= write_data;
        end
    end

    assign done      = !miss;
    assign read_data = filling ? mem_data_out : data_q[idx]; // bypass on the fill cycle

    // write-through so memory sees every store whether or not it hits
    assign mem_addr     = addr;
    assign mem_data_in  = write_data;
    assign mem_write_en = write_req && !filling;

endmodule

`default_nettype wire

// File: design/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_core (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic [`MIPS_WORD_W-1:0] inst,
    output logic [`MIPS_WORD_W-1:0] inst_addr,
    output logic [`MIPS_WORD_W-1:0] mem_addr,
    input  mips_pkg::mem_word_t     mem_data_out,
    output mips_pkg::mem_word_t     mem_data_in,
    output logic                    mem_write_en,
    output logic                    halted
);

    import mips_pkg::*;

    ctrl_t ctrl;
    logic  syscall_dec;
    logic  zero;
    logic  cache_done;
    logic  retire;      // pc, regfile and store commit together

    logic [`MIPS_WORD_W-1:0] pc_q;
    logic [`MIPS_WORD_W-1:0] rs_data, rt_data;
    logic [`MIPS_WORD_W-1:0] sign_ext, alu_b, alu_result;
    logic [`MIPS_WORD_W-1:0] read_data, wb_data;
    logic [`MIPS_WORD_W-1:0] pc_plus4, branch_target, jump_target, next_pc;
    logic [4:0]              rd_num;

    mips_control mips_control_inst (
        .opcode  (opcode_e'(inst[31:26])),
        .funct   (funct_e'(inst[5:0])),
        .ctrl    (ctrl),
        .syscall (syscall_dec)
    );

    assign rd_num  = ctrl.reg_dst ? inst[15:11] : inst[20:16];
    assign wb_data = ctrl.mem_to_reg ? read_data : alu_result;

    mips_regfile mips_regfile_inst (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (inst[25:21]),
        .rt_num  (inst[20:16]),
        .rd_num  (rd_num),
        .rd_data (wb_data),
        .rd_we   (ctrl.reg_write),
        .stall   (~cache_done),
        .halted  (halted),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign sign_ext = {{16{inst[15]}}, inst[15:0]};
    assign alu_b    = ctrl.alu_src ? sign_ext : rt_data;

    mips_alu mips_alu_inst (
        .a      (rs_data),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    mips_cache mips_cache_inst (
        .clk          (clk),
        .rst_b        (rst_b),
        .addr         (alu_result),
        .read_req     (ctrl.mem_read & ~halted),
        .write_req    (ctrl.mem_write & ~halted), // no stores once halted
        .write_data   (rt_data),
        .read_data    (read_data),
        .done         (cache_done),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .mem_write_en (mem_write_en)
    );

    assign pc_plus4      = pc_q + 32'd4;
    assign branch_target = pc_plus4 + {sign_ext[`MIPS_WORD_W-3:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], inst[25:0], 2'b00}; // pseudo-direct
    always_comb begin
        next_pc = pc_plus4;
        if (ctrl.jump) next_pc = jump_target;
        else if (ctrl.branch && zero) next_pc = branch_target;
    end

    assign retire = cache_done && !halted;

    always_ff @(posedge clk) begin
        if (!rst_b) pc_q <= `RESET_PC;
        else if (retire) pc_q <= next_pc; // holds while a miss waits and after halt
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_b) halted <= 1'b0;
        else if (syscall_dec && retire) halted <= 1'b1;
    end

    assign inst_addr = pc_q;

endmodule

`default_nettype wire

// File: test/mips_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_tb;

    import mips_pkg::*;

    localparam int ROM_WORDS = 128;
    localparam int MEM_WORDS = 64;

    logic                    clk;
    logic                    rst_b;
    logic [`MIPS_WORD_W-1:0] inst;
    logic [`MIPS_WORD_W-1:0] inst_addr;
    logic [`MIPS_WORD_W-1:0] mem_addr;
    mem_word_t               mem_data_out;
    mem_word_t               mem_data_in;
    logic                    mem_write_en;
    logic                    halted;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic        mem_load;  // reload dmem with the fill pattern
    logic [31:0] m_regs [32];      // reference register file
    logic [31:0] m_mem [MEM_WORDS];
    logic [31:0] exp_pc [$];       // model pc trace including syscall
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] lfsr_q;
    logic [31:0] last_pc;
    int          prog_len, limit, pc_idx, st_idx, stay;
    int          mismatches, other_errors;
    logic        ok;

    mips_core mips_core_inst (
        .clk          (clk),
        .rst_b        (rst_b),
        .inst         (inst),
        .inst_addr    (inst_addr),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign inst         = rom[inst_addr[8:2]]; // instruction port answers at once
    assign mem_data_out = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_load) begin
            for (int i = 0; i < MEM_WORDS; i++) dmem[i] <= fill_word(i);
        end else if (mem_write_en) begin
            dmem[mem_addr[7:2]] <= mem_data_in;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h0103_0507) ^ 32'hc0de_0000; // every address bit matters
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]}; // one step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, input funct_e fn);
        return {op_r_type, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic funct_e pick_funct(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return fn_add;
            3'd1, 3'd6: return fn_sub;
            3'd2:       return fn_and;
            3'd3, 3'd7: return fn_or;
            default:    return fn_slt;
        endcase
    endfunction

    task automatic build_program();
        int         n;
        logic [2:0] sel;
        logic [4:0] r1;
        logic [4:0] r2;
        logic [4:0] r3;
        n = 0;
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = enc_r(5'd0, 5'd0, 5'd0, fn_syscall);
        for (int i = 0; i < 8; i++) begin
            r2     = 5'(rand_bits(5));
            rom[n] = enc_i(op_addi, 5'd0, r2, 16'(rand_bits(16))); // seed regs
            n++;
        end
        for (int i = 0; i < 60; i++) begin
            sel = 3'(rand_bits(3));
            r1  = 5'(rand_bits(5));
            case (sel)
                3'd0, 3'd1: begin
                    r2     = 5'(rand_bits(5));
                    r3     = 5'(rand_bits(5));
                    rom[n] = enc_r(r1, r2, r3, pick_funct(3'(rand_bits(3))));
                end
                3'd2: begin
                    r2     = 5'(rand_bits(5));
                    rom[n] = enc_i(op_addi, r1, r2, 16'(rand_bits(16)));
                end
                3'd3, 3'd4: rom[n] = enc_i(op_lw, 5'd0, r1, 16'(rand_bits(5) << 2)); // 32 words
                3'd5, 3'd6: rom[n] = enc_i(op_sw, 5'd0, r1, 16'(rand_bits(5) << 2));
                default: begin
                    r2     = (rand_bits(1) != 0) ? r1 : 5'(rand_bits(5)); // half taken
                    rom[n] = enc_i(op_beq, r1, r2, 16'(1 + rand_bits(2) % 3));
                end
            endcase
            n++;
        end
        rom[n] = {op_j, 26'(n + 2)}; // jump over the dead slot
        n++;
        rom[n] = enc_i(op_addi, 5'd0, 5'd1, 16'h7777); // dead slot that clobbers r1 if run
        n++;
        for (int r = 1; r < 32; r++) begin
            rom[n] = enc_i(op_sw, 5'd0, 5'(r), 16'(124 + 4 * r)); // dump to words 32..62
            n++;
        end
        rom[n]   = enc_r(5'd0, 5'd0, 5'd0, fn_syscall);
        prog_len = n + 1;
    endtask

    function automatic void write_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) m_regs[r] = v;
    endfunction

    // instruction-set model that builds the pc trace, store list and final memory
    task automatic run_model();
        logic [31:0] pc, nxt, ins, a, b, imm, addr;
        logic        stop;
        pc   = `RESET_PC;
        stop = 1'b0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) m_mem[i] = fill_word(i);
        for (int step = 0; step < ROM_WORDS && !stop; step++) begin
            ins  = rom[pc[8:2]];
            a    = m_regs[ins[25:21]];
            b    = m_regs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm; // effective address of lw and sw
            nxt  = pc + 32'd4;
            exp_pc.push_back(pc);
            case (ins[31:26])
                op_r_type: begin
                    case (ins[5:0])
                        fn_add:     write_reg(ins[15:11], a + b);
                        fn_sub:     write_reg(ins[15:11], a - b);
                        fn_and:     write_reg(ins[15:11], a & b);
                        fn_or:      write_reg(ins[15:11], a | b);
                        fn_slt:     write_reg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        fn_syscall: stop = 1'b1;
                        default:    ;
                    endcase
                end
                op_addi: write_reg(ins[20:16], a + imm);
                op_lw:   write_reg(ins[20:16], m_mem[addr[7:2]]);
                op_sw: begin
                    m_mem[addr[7:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                op_beq:  if (a == b) nxt = nxt + (imm << 2); // offset counts words after pc + 4
                op_j:    nxt = {nxt[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            pc = nxt;
        end
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_b    <= 1'b0;
        mem_load <= 1'b1; // fresh data memory for every run
        repeat (10) @(posedge clk);
        rst_b    <= 1'b1;
        mem_load <= 1'b0;
        check(inst_addr, `RESET_PC, "pc after reset");
        check(32'(mem_write_en), 32'd0, "mem_write_en during reset");
        check(32'(halted), 32'd0, "halted during reset");
    endtask

    // one sampled cycle while the core runs
    task automatic observe();
        if (inst_addr !== last_pc) begin
            if (pc_idx < exp_pc.size()) begin
                check(inst_addr, exp_pc[pc_idx], "retire pc");
            end else begin
                other_errors++;
                $display("ERROR %0t: core fetched past the end of the program", $time);
            end
            pc_idx++;
            last_pc = inst_addr;
            stay    = 1;
        end else begin
            stay++;
            check(32'(stay > ((inst[31:26] == op_lw) ? 2 : 1)), 32'd0, "stall length");
        end
        if (mem_write_en) begin
            if (st_idx < exp_st_addr.size()) begin
                check(mem_addr, exp_st_addr[st_idx], "store address");
                check(mem_data_in, exp_st_data[st_idx], "store data");
            end else begin
                other_errors++;
                $display("ERROR %0t: core made more stores than the program", $time);
            end
            st_idx++;
        end
    endtask

    task automatic run_program(output logic done_ok);
        int cycles;
        cycles  = 0;
        pc_idx  = 0;
        st_idx  = 0;
        stay    = 0;
        last_pc = '1;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (!halted) observe();
        end
        done_ok = halted;
        if (!halted) begin
            other_errors++;
            $display("ERROR %0t: timeout, core did not halt within %0d cycles", $time, limit);
        end else begin
            check(32'(pc_idx), 32'(exp_pc.size()), "retired instruction count");
            check(32'(st_idx), 32'(exp_st_addr.size()), "store count");
        end
    endtask

    task automatic finish_checks();
        logic [31:0] hold_pc;
        hold_pc = inst_addr;
        repeat (20) begin
            @(posedge clk);
            check(inst_addr, hold_pc, "pc after halt");
            check(32'(mem_write_en), 32'd0, "store after halt");
            check(32'(halted), 32'd1, "halted dropped");
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check(dmem[i], m_mem[i], $sformatf("memory word %0d", i));
        end
    endtask

    initial begin
        rst_b        <= 1'b0;
        mem_load     <= 1'b1;
        lfsr_q       = 32'hc65;
        mismatches   = 0;
        other_errors = 0;
        build_program();
        run_model();
        limit = 4 * prog_len + 100;
        apply_reset();
        run_program(ok);
        if (ok) begin
            finish_checks();
            apply_reset();
            repeat (40) @(posedge clk); // partial run before a reset mid-program
            apply_reset();
            run_program(ok);
            if (ok) finish_checks();
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/mips_pkg.sv
design/mips_control.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_cache.sv
design/mips_core.sv
test/mips_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module mips_tb -f compile.f -o mips_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/mips_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
